// ==== flist.f ====
+incdir+hdl
+incdir+verification
hdl/accel_cfg_pkg.sv
hdl/accel_ctrl_pkg.sv
hdl/accel_reg_slave.sv
hdl/accel_cfg_tiler.sv
hdl/accel_ctrl_fsm.sv
hdl/accel_tile_scheduler.sv
hdl/accel_top.sv
verification/accel_tb.sv

// ==== verification/accel_tb_tasks.svh ====
// Peripheral port access and directed test tasks for the controller testbench.
// Included inside the testbench module, which provides the signals, the
// check task and the event counters.

`ifndef ACCEL_TB_TASKS_SVH
`define ACCEL_TB_TASKS_SVH

// Write takes effect at the granting edge
task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
  req.req  = 1'b1;
  req.wen  = 1'b0;
  req.add  = addr;
  req.data = data;
  @(negedge clk);
  check_eq("gnt", rsp.gnt, 1);
  wait_cycle();
  req = '0;
endtask

// Response must come exactly one cycle after the grant
task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
  req.req  = 1'b1;
  req.wen  = 1'b1;
  req.add  = addr;
  req.data = '0;
  @(negedge clk);
  check_eq("gnt", rsp.gnt, 1);
  check_eq("r_valid in grant cycle", rsp.r_valid, 0);
  wait_cycle();
  req = '0;
  @(negedge clk);
  check_eq("r_valid", rsp.r_valid, 1);
  data = rsp.r_data;
  wait_cycle();
endtask

task automatic wait_busy(input logic level, input int unsigned limit);
  int unsigned n;
  n = 0;
  while (busy !== level && n < limit) begin
    wait_cycle();
    n++;
  end
  check_eq("busy_o", busy, level);
endtask

task automatic wait_evt(input int unsigned base, input int unsigned limit);
  int unsigned n;
  n = 0;
  while (evt_cnt == base && n < limit) begin
    wait_cycle();
    n++;
  end
  if (evt_cnt == base) report_error("no evt_o pulse within the job time limit");
endtask

task automatic run_job(input int unsigned m, input int unsigned n, input int unsigned k);
  int unsigned evt0;
  int unsigned flush0;
  logic [31:0] res;
  reg_write(REG_M, m);
  reg_write(REG_N, n);
  reg_write(REG_K, k);
  evt0   = evt_cnt;
  flush0 = flush_cnt;
  reg_write(REG_TRIGGER, 32'h1);
  wait_evt(evt0, job_len(m, n, k));
  repeat (4) wait_cycle();
  check_eq("evt_o pulses", evt_cnt - evt0, 1);
  check_eq("flush_o pulses", flush_cnt - flush0, 1);
  reg_read(REG_RESULT, res);
  check_eq("REG_RESULT", res, expected_tiles(m, n));
endtask

task automatic test_readback();
  int unsigned e0;
  logic [31:0] rd;
  e0 = errors;
  reg_write(REG_M, 32'h5a3);
  reg_write(REG_N, 32'h0c7);
  reg_write(REG_K, 32'hf1e);
  reg_read(REG_M, rd);
  check_eq("REG_M", rd, 32'h5a3);
  reg_read(REG_N, rd);
  check_eq("REG_N", rd, 32'h0c7);
  reg_read(REG_K, rd);
  check_eq("REG_K", rd, 32'hf1e);
  end_test("readback", e0);
endtask

task automatic test_job_status();
  int unsigned e0;
  int unsigned evt0;
  logic [31:0] st;
  e0   = errors;
  evt0 = evt_cnt;
  reg_write(REG_M, StsM);
  reg_write(REG_N, StsN);
  reg_write(REG_K, StsK);
  reg_write(REG_TRIGGER, 32'h0);
  wait_busy(1'b1, 8);
  reg_read(REG_STATUS, st);
  check_eq("REG_STATUS busy bit", st[0], 1);
  check_eq("evt_o pulses before end", evt_cnt - evt0, 0);
  wait_evt(evt0, job_len(StsM, StsN, StsK));
  check_eq("busy_o", busy, 0);
  repeat (4) wait_cycle();
  check_eq("evt_o pulses", evt_cnt - evt0, 1);
  reg_read(REG_STATUS, st);
  check_eq("REG_STATUS", st, 32'h2);
  end_test("job status", e0);
endtask

task automatic test_tile_count();
  int unsigned e0;
  logic [35:0] s;
  e0 = errors;
  for (int i = 0; i < NumShapes; i++) begin
    s = shape(i);
    run_job(s[35:24], s[23:12], s[11:0]);
  end
  end_test("tile count", e0);
endtask

// Clear lands in the compute phase of a long job
task automatic test_soft_clear();
  int unsigned e0;
  int unsigned evt0;
  logic [31:0] st;
  e0   = errors;
  evt0 = evt_cnt;
  reg_write(REG_M, ClrM);
  reg_write(REG_N, ClrN);
  reg_write(REG_K, ClrK);
  reg_write(REG_TRIGGER, 32'h1);
  wait_busy(1'b1, 8);
  repeat (20) wait_cycle();
  reg_write(REG_CLEAR, 32'h1);
  check_eq("clear_o", clear, 1);
  wait_busy(1'b0, 2);
  check_eq("clear_o", clear, 0);
  // Longer than the whole job, so a job that kept running would end here
  repeat (job_len(ClrM, ClrN, ClrK)) wait_cycle();
  check_eq("evt_o pulses", evt_cnt - evt0, 0);
  reg_read(REG_STATUS, st);
  check_eq("REG_STATUS", st, 32'h0);
  end_test("soft clear", e0);
endtask

task automatic test_test_mode();
  int unsigned e0;
  int unsigned evt0;
  e0   = errors;
  evt0 = evt_cnt;
  test_mode = 1'b1;
  wait_busy(1'b1, 4);
  test_mode = 1'b0;
  wait_evt(evt0, job_len(ClrM, ClrN, ClrK));
  check_eq("busy_o", busy, 0);
  end_test("test mode", e0);
endtask

task automatic test_random_jobs();
  int unsigned e0;
  int unsigned m;
  int unsigned n;
  int unsigned k;
  e0 = errors;
  for (int i = 0; i < NumRandJobs; i++) begin
    m = rand_bits(6);
    n = rand_bits(6);
    k = rand_bits(4);
    run_job(m, n, k);
  end
  end_test("random jobs", e0);
endtask

`endif

// ==== verification/accel_tb.sv ====
// Testbench for the tile-job controller.
// Drives accel_top over the peripheral port through directed register, job,
// clear and test mode tests and a set of LFSR-sized jobs. Prints one line
// per test and a closing line with the counts.

`timescale 1ns/1ps

`include "accel_macros.svh"

module accel_tb;
  import accel_cfg_pkg::*;
  import accel_ctrl_pkg::*;

  localparam int unsigned ClkPeriod   = 10;
  localparam int unsigned RstCycles   = 16;
  localparam int unsigned NumTests    = 6;
  localparam int unsigned NumShapes   = 6;
  localparam int unsigned NumRandJobs = 8;
  localparam int unsigned JobOverhead = 40;
  localparam int unsigned TestMargin  = 100;
  // Job shape of the status test
  localparam int unsigned StsM = 8;
  localparam int unsigned StsN = 16;
  localparam int unsigned StsK = 3;
  // Job shape shared by the soft clear and test mode tests
  localparam int unsigned ClrM = 16;
  localparam int unsigned ClrN = 32;
  localparam int unsigned ClrK = 10;

  logic        clk;
  logic        rst_n;
  logic        test_mode;
  periph_req_t req;
  periph_rsp_t rsp;
  logic        busy;
  logic        clear;
  logic        flush;
  logic        evt;
  logic [31:0] lfsr_q;
  int unsigned errors    = 0;
  int unsigned checks    = 0;
  int unsigned tests_run = 0;
  int unsigned evt_cnt   = 0;
  int unsigned flush_cnt = 0;

  accel_top dut_i (
    .clk_i        ( clk       ),
    .rst_ni       ( rst_n     ),
    .test_mode_i  ( test_mode ),
    .periph_req_i ( req       ),
    .periph_rsp_o ( rsp       ),
    .busy_o       ( busy      ),
    .clear_o      ( clear     ),
    .flush_o      ( flush     ),
    .evt_o        ( evt       )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Event and flush pulses counted away from the active edge
  always @(negedge clk) begin
    if (evt) evt_cnt++;
    if (flush) flush_cnt++;
  end

  // Galois LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int unsigned rand_bits(input int unsigned nbits);
    int unsigned v;
    v = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = (v << 1) | lfsr_q[0];
    end
    return v;
  endfunction

  // Whole tiles needed to cover an M by N output
  function automatic int unsigned expected_tiles(input int unsigned m, input int unsigned n);
    return ((m + `ACCEL_TILE_H - 1) / `ACCEL_TILE_H) * ((n + `ACCEL_TILE_W - 1) / `ACCEL_TILE_W);
  endfunction

  // Worst case cycles for one job including its register accesses
  function automatic int unsigned job_len(input int unsigned m, input int unsigned n,
                                          input int unsigned k);
    return (k + 1) * (expected_tiles(m, n) + 1) + JobOverhead;
  endfunction

  // Tile count shapes packed as M, N and K
  function automatic logic [35:0] shape(input int unsigned idx);
    case (idx)
      0:       return {12'd4, 12'd8, 12'd0};
      1:       return {12'd5, 12'd9, 12'd2};
      2:       return {12'd13, 12'd17, 12'd5};
      3:       return {12'd0, 12'd16, 12'd4};
      4:       return {12'd33, 12'd70, 12'd7};
      default: return {12'd12, 12'd0, 12'd1};
    endcase
  endfunction

  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic end_test(input string name, input int unsigned err_before);
    tests_run++;
    if (errors == err_before) $display("test %s: pass", name);
    else $display("test %s: %0d errors", name, errors - err_before);
  endtask

  `include "accel_tb_tasks.svh"

  initial begin : watchdog
    logic [35:0] s;
    int unsigned budget;
    budget = RstCycles + NumTests * TestMargin + job_len(StsM, StsN, StsK);
    for (int i = 0; i < NumShapes; i++) begin
      s = shape(i);
      budget += job_len(s[35:24], s[23:12], s[11:0]);
    end
    budget += 2 * job_len(ClrM, ClrN, ClrK);
    budget += NumRandJobs * job_len(63, 63, 15);
    repeat (budget) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", budget);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    test_mode = 1'b0;
    req       = '0;
    lfsr_q    = 32'h7d7c_7cbf;
    repeat (RstCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // FSM still in LATCH_RST right after reset
    check_eq("clear_o", clear, 1);
    repeat (3) wait_cycle();
    check_eq("busy_o", busy, 0);
    check_eq("clear_o", clear, 0);
    check_eq("evt_o", evt, 0);
    check_eq("flush_o", flush, 0);
    test_readback();
    test_job_status();
    test_tile_count();
    test_soft_clear();
    test_test_mode();
    test_random_jobs();
    $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== hdl/accel_top.sv ====
// Top level of the tile-job controller.
// Connects register slave, configuration tiler, controller FSM and tile
// scheduler. The host talks to it over the peripheral request and response
// structs and watches evt_o for job completion.

`timescale 1ns/1ps

module accel_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        test_mode_i,
  input  accel_ctrl_pkg::periph_req_t periph_req_i,
  output accel_ctrl_pkg::periph_rsp_t periph_rsp_o,
  output logic                        busy_o,
  output logic                        clear_o,
  output logic                        flush_o,
  output logic                        evt_o
);
  import accel_cfg_pkg::*;
  import accel_ctrl_pkg::*;

  regfile_t     regfile;
  tiled_cfg_t   cfg;
  sched_ctrl_t  sched_ctrl;
  sched_flags_t sched_flags;
  logic         start;
  logic         slv_clear;
  logic         cfg_valid;
  logic         setback;
  logic         done;

  accel_reg_slave i_reg_slave (
    .clk_i        ( clk_i                  ),
    .rst_ni       ( rst_ni                 ),
    .periph_req_i ( periph_req_i           ),
    .periph_rsp_o ( periph_rsp_o           ),
    .busy_i       ( busy_o                 ),
    .done_i       ( done                   ),
    .tiles_done_i ( sched_flags.tiles_done ),
    .regfile_o    ( regfile                ),
    .start_o      ( start                  ),
    .clear_o      ( slv_clear              ),
    .evt_o        ( evt_o                  )
  );

  accel_cfg_tiler i_cfg_tiler (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .clear_i     ( clear_o   ),
    .setback_i   ( setback   ),
    .start_cfg_i ( start     ),
    .regfile_i   ( regfile   ),
    .cfg_valid_o ( cfg_valid ),
    .cfg_o       ( cfg       )
  );

  accel_ctrl_fsm i_ctrl_fsm (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .test_mode_i ( test_mode_i ),
    .clear_i     ( slv_clear   ),
    .start_i     ( start       ),
    .cfg_valid_i ( cfg_valid   ),
    .flags_i     ( sched_flags ),
    .ctrl_o      ( sched_ctrl  ),
    .setback_o   ( setback     ),
    .busy_o      ( busy_o      ),
    .flush_o     ( flush_o     ),
    .done_o      ( done        ),
    .clear_o     ( clear_o     )
  );

  accel_tile_scheduler i_tile_scheduler (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .clear_i ( clear_o     ),
    .ctrl_i  ( sched_ctrl  ),
    .cfg_i   ( cfg         ),
    .flags_o ( sched_flags )
  );

endmodule

// ==== hdl/accel_tile_scheduler.sv ====
// Tile scheduler of the tile-job controller.
// Stands in for the datapath: it times the weight preload, then spends
// K+1 cycles on each tile back to back and counts the tiles done.

`timescale 1ns/1ps

module accel_tile_scheduler (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  accel_ctrl_pkg::sched_ctrl_t  ctrl_i,
  input  accel_cfg_pkg::tiled_cfg_t    cfg_i,
  output accel_ctrl_pkg::sched_flags_t flags_o
);
  import accel_cfg_pkg::*;

  tiled_cfg_t cfg_q;
  dim_t       pre_cnt_q;
  dim_t       cyc_cnt_q;
  tiles_t     tiles_q;
  logic       loaded_q;
  logic       w_loaded;
  logic       z_done;
  logic       tile_end;
  logic       rst_cnt;

  assign rst_cnt = clear_i || ctrl_i.finished;

  // Preload ends after K cycles, or one cycle for K of zero
  assign w_loaded = ctrl_i.first_load &&
                    ((cfg_q.k_len == '0) || (pre_cnt_q == cfg_q.k_len - dim_t'(1)));
  assign z_done   = loaded_q && (tiles_q == cfg_q.total_tiles);
  assign tile_end = loaded_q && !z_done && (cyc_cnt_q == cfg_q.k_len);

  // Job description frozen while a job runs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (!ctrl_i.first_load && !loaded_q) begin
      cfg_q <= cfg_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pre_cnt_q <= '0;
      cyc_cnt_q <= '0;
      tiles_q   <= '0;
      loaded_q  <= 1'b0;
    end else if (rst_cnt) begin
      pre_cnt_q <= '0;
      cyc_cnt_q <= '0;
      tiles_q   <= '0;
      loaded_q  <= 1'b0;
    end else begin
      if (ctrl_i.first_load) pre_cnt_q <= pre_cnt_q + dim_t'(1);
      if (w_loaded) loaded_q <= 1'b1;
      if (tile_end) begin
        cyc_cnt_q <= '0;
        tiles_q   <= tiles_q + tiles_t'(1);
      end else if (loaded_q && !z_done) begin
        cyc_cnt_q <= cyc_cnt_q + dim_t'(1);
      end
    end
  end

  always_comb begin
    flags_o.w_loaded   = w_loaded;
    flags_o.z_done     = z_done;
    flags_o.tiles_done = tiles_q;
  end

endmodule

// ==== hdl/accel_ctrl_fsm.sv ====
// Job state machine of the tile-job controller.
// Latches the start strobe, waits for a valid configuration and walks the
// job through preload, computation and finish. Also combines the soft clear
// with the post-reset state into the clear seen by the other stages.

`timescale 1ns/1ps

module accel_ctrl_fsm (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         test_mode_i,
  input  logic                         clear_i,
  input  logic                         start_i,
  input  logic                         cfg_valid_i,
  input  accel_ctrl_pkg::sched_flags_t flags_i,
  output accel_ctrl_pkg::sched_ctrl_t  ctrl_o,
  output logic                         setback_o,
  output logic                         busy_o,
  output logic                         flush_o,
  output logic                         done_o,
  output logic                         clear_o
);
  import accel_ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        start_q;
  logic        setback;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LATCH_RST;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Trigger seen while busy is kept for the next job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
    end else if (clear_i) begin
      start_q <= 1'b0;
    end else if (start_i) begin
      start_q <= 1'b1;
    end else if (setback) begin
      start_q <= 1'b0;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      LATCH_RST: state_d = IDLE;
      IDLE: begin
        if ((start_q && cfg_valid_i) || test_mode_i) state_d = STARTING;
      end
      STARTING: begin
        if (flags_i.w_loaded) state_d = COMPUTING;
      end
      COMPUTING: begin
        if (flags_i.z_done) state_d = FINISHED;
      end
      FINISHED: state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  // Configuration is consumed on the way out of IDLE
  assign setback = (state_q == IDLE) && (state_d == STARTING);

  always_comb begin
    ctrl_o.first_load = state_q == STARTING;
    ctrl_o.finished   = state_q == FINISHED;
  end

  assign setback_o = setback;
  assign busy_o    = (state_q == STARTING) || (state_q == COMPUTING);
  assign flush_o   = state_q == FINISHED;
  assign done_o    = state_q == FINISHED;
  assign clear_o   = clear_i || (state_q == LATCH_RST);

endmodule

// ==== hdl/accel_cfg_tiler.sv ====
// Configuration tiler of the tile-job controller.
// On the start strobe it samples the live sizes, rounds M and N up to whole
// tiles and registers the job description. The description stays valid until
// the FSM consumes it with setback, or until a clear.

`timescale 1ns/1ps

`include "accel_macros.svh"

module accel_cfg_tiler (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      setback_i,
  input  logic                      start_cfg_i,
  input  accel_cfg_pkg::regfile_t   regfile_i,
  output logic                      cfg_valid_o,
  output accel_cfg_pkg::tiled_cfg_t cfg_o
);
  import accel_cfg_pkg::*;

  localparam int unsigned DimW = `ACCEL_DIM_W;

  // One extra bit so the round-up cannot wrap
  localparam logic [DimW:0] TileH    = (DimW+1)'(`ACCEL_TILE_H);
  localparam logic [DimW:0] TileW    = (DimW+1)'(`ACCEL_TILE_W);
  localparam logic [DimW:0] TileHRnd = (DimW+1)'(`ACCEL_TILE_H - 1);
  localparam logic [DimW:0] TileWRnd = (DimW+1)'(`ACCEL_TILE_W - 1);

  logic [DimW:0] m_ceil;
  logic [DimW:0] n_ceil;
  tiled_cfg_t    cfg_d;
  tiled_cfg_t    cfg_q;
  logic          valid_q;

  always_comb begin
    m_ceil            = ({1'b0, regfile_i.m} + TileHRnd) / TileH;
    n_ceil            = ({1'b0, regfile_i.n} + TileWRnd) / TileW;
    cfg_d.m_tiles     = m_ceil[DimW-1:0];
    cfg_d.n_tiles     = n_ceil[DimW-1:0];
    cfg_d.k_len       = regfile_i.k;
    cfg_d.total_tiles = tiles_t'(m_ceil[DimW-1:0]) * tiles_t'(n_ceil[DimW-1:0]);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q   <= '0;
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else if (start_cfg_i) begin
      // A new trigger wins over a setback in the same cycle
      cfg_q   <= cfg_d;
      valid_q <= 1'b1;
    end else if (setback_i) begin
      valid_q <= 1'b0;
    end
  end

  assign cfg_valid_o = valid_q;
  assign cfg_o       = cfg_q;

endmodule

// ==== hdl/accel_reg_slave.sv ====
// Peripheral register slave of the tile-job controller.
// Grants every request in the same cycle, applies writes at the granting
// edge and returns read data one cycle later. Produces the start and soft
// clear strobes and turns the FSM done pulse into the completion event.

`timescale 1ns/1ps

`include "accel_macros.svh"

module accel_reg_slave (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  accel_ctrl_pkg::periph_req_t periph_req_i,
  output accel_ctrl_pkg::periph_rsp_t periph_rsp_o,
  input  logic                        busy_i,
  input  logic                        done_i,
  input  accel_cfg_pkg::tiles_t       tiles_done_i,
  output accel_cfg_pkg::regfile_t     regfile_o,
  output logic                        start_o,
  output logic                        clear_o,
  output logic                        evt_o
);
  import accel_cfg_pkg::*;

  localparam int unsigned DW      = `ACCEL_DW;
  localparam int unsigned DimW    = `ACCEL_DIM_W;
  localparam int unsigned NumRegs = `ACCEL_NUM_REGS;

  reg_addr_e       addr;
  logic            addr_ok;
  logic            wr_en;
  logic            rd_en;
  regfile_t        regfile_q;
  tiles_t          result_q;
  logic            done_sticky_q;
  logic            start_q;
  logic            clear_q;
  logic            evt_q;
  logic            r_valid_q;
  logic [DW-1:0]   r_data_d;
  logic [DW-1:0]   r_data_q;

  assign addr    = reg_addr_e'(periph_req_i.add);
  assign addr_ok = 32'(periph_req_i.add) < NumRegs;
  assign wr_en   = periph_req_i.req && !periph_req_i.wen && addr_ok;
  assign rd_en   = periph_req_i.req && periph_req_i.wen;

  // Register file and strobes written at the granting edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regfile_q <= '0;
      start_q   <= 1'b0;
      clear_q   <= 1'b0;
    end else begin
      start_q <= wr_en && (addr == REG_TRIGGER);
      clear_q <= wr_en && (addr == REG_CLEAR);
      if (wr_en && (addr == REG_M)) regfile_q.m <= periph_req_i.data[DimW-1:0];
      if (wr_en && (addr == REG_N)) regfile_q.n <= periph_req_i.data[DimW-1:0];
      if (wr_en && (addr == REG_K)) regfile_q.k <= periph_req_i.data[DimW-1:0];
    end
  end

  // The event trails the done pulse by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q      <= '0;
      done_sticky_q <= 1'b0;
      evt_q         <= 1'b0;
    end else begin
      evt_q <= done_i && !clear_q;
      if (done_i) result_q <= tiles_done_i;
      if (clear_q || (wr_en && (addr == REG_TRIGGER || addr == REG_CLEAR))) begin
        done_sticky_q <= 1'b0;
      end else if (done_i) begin
        done_sticky_q <= 1'b1;
      end
    end
  end

  always_comb begin
    r_data_d = '0;
    case (addr)
      REG_M:      r_data_d = DW'(regfile_q.m);
      REG_N:      r_data_d = DW'(regfile_q.n);
      REG_K:      r_data_d = DW'(regfile_q.k);
      REG_STATUS: r_data_d = DW'({done_sticky_q, busy_i});
      REG_RESULT: r_data_d = DW'(result_q);
      default:    r_data_d = '0;
    endcase
  end

  // Read response one cycle after the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
    end else begin
      r_valid_q <= rd_en;
      if (rd_en) r_data_q <= r_data_d;
    end
  end

  always_comb begin
    periph_rsp_o.gnt     = periph_req_i.req;
    periph_rsp_o.r_valid = r_valid_q;
    periph_rsp_o.r_data  = r_data_q;
  end

  assign regfile_o = regfile_q;
  assign start_o   = start_q;
  assign clear_o   = clear_q;
  assign evt_o     = evt_q;

endmodule

// ==== hdl/accel_ctrl_pkg.sv ====
// Control types of the tile-job controller.
// Covers the FSM states, the peripheral port structs and the handshake
// between the controller FSM and the tile scheduler.

`include "accel_macros.svh"

package accel_ctrl_pkg;

  typedef enum logic [2:0] {
    LATCH_RST,
    IDLE,
    STARTING,
    COMPUTING,
    FINISHED
  } ctrl_state_e;

  // wen low means write
  typedef struct packed {
    logic                 req;
    logic                 wen;
    logic [`ACCEL_AW-1:0] add;
    logic [`ACCEL_DW-1:0] data;
  } periph_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 r_valid;
    logic [`ACCEL_DW-1:0] r_data;
  } periph_rsp_t;

  typedef struct packed {
    logic first_load;
    logic finished;
  } sched_ctrl_t;

  typedef struct packed {
    logic                      w_loaded;
    logic                      z_done;
    logic [`ACCEL_TILES_W-1:0] tiles_done;
  } sched_flags_t;

endpackage

// ==== hdl/accel_cfg_pkg.sv ====
// Configuration types of the tile-job controller.
// Holds the register map, the programmed sizes and the tiled job description.
// Modules refer to these types by scoped name in their ports and import the
// package in the body where they use it.

`include "accel_macros.svh"

package accel_cfg_pkg;

  typedef logic [`ACCEL_DIM_W-1:0]   dim_t;
  typedef logic [`ACCEL_TILES_W-1:0] tiles_t;

  // Word offsets on the peripheral port
  typedef enum logic [`ACCEL_AW-1:0] {
    REG_M       = 3'd0,
    REG_N       = 3'd1,
    REG_K       = 3'd2,
    REG_TRIGGER = 3'd3,
    REG_STATUS  = 3'd4,
    REG_RESULT  = 3'd5,
    REG_CLEAR   = 3'd6
  } reg_addr_e;

  // Sizes as programmed by the host
  typedef struct packed {
    dim_t m;
    dim_t n;
    dim_t k;
  } regfile_t;

  // Job description after tiling
  typedef struct packed {
    dim_t   m_tiles;
    dim_t   n_tiles;
    dim_t   k_len;
    tiles_t total_tiles;
  } tiled_cfg_t;

endpackage

// ==== hdl/accel_macros.svh ====
// Global sizing constants for the tile-job controller.
// Included by the packages and by any module that needs raw widths.

`ifndef ACCEL_MACROS_SVH
`define ACCEL_MACROS_SVH

// Tile geometry in rows and columns
`define ACCEL_TILE_H 4
`define ACCEL_TILE_W 8

// Peripheral port widths
`define ACCEL_DW 32
`define ACCEL_AW 3

// Number of decoded registers behind the port
`define ACCEL_NUM_REGS 7

// Width of each M, N and K field
`define ACCEL_DIM_W 12

// Width of the tile counters and the result register
`define ACCEL_TILES_W 24

`endif
